//--- board_io.f
src/board_pkg.sv
src/player_if.sv
src/reset_seq.sv
src/input_sampler.sv
src/player_map.sv
src/input_merge.sv
src/dip_decode.sv
src/board_io_top.sv
testbench/tb_board_io.sv

//--- src/board_io_top.sv
`timescale 1ns/1ps

module board_io_top (
    input  logic                             clk_sys,
    input  logic                             rst_n,
    input  logic                             pll_locked,
    input  logic                             rst_req,
    input  logic                             downloading,
    input  logic [board_pkg::BOARD_JOY_W-1:0] board_joystick1,
    input  logic [board_pkg::BOARD_JOY_W-1:0] board_joystick2,
    input  logic [board_pkg::BOARD_JOY_W-1:0] board_joystick3,
    input  logic [board_pkg::BOARD_JOY_W-1:0] board_joystick4,
    input  logic [board_pkg::STATUS_W-1:0]   status,
    input  logic [board_pkg::CORE_MOD_W-1:0] core_mod,
    output logic                             game_rst_n,
    output logic [board_pkg::GAME_JOY_W-1:0] game_joystick1,
    output logic [board_pkg::GAME_JOY_W-1:0] game_joystick2,
    output logic [board_pkg::GAME_JOY_W-1:0] game_joystick3,
    output logic [board_pkg::GAME_JOY_W-1:0] game_joystick4,
    output logic [board_pkg::NUM_PLAYERS-1:0] game_coin,
    output logic [board_pkg::NUM_PLAYERS-1:0] game_start,
    output logic                             game_service,
    output logic                             game_pause,
    output logic                             dip_test,
    output logic                             dip_pause,
    output logic                             dip_flip,
    output logic [1:0]                       dip_fxlevel,
    output logic                             enable_fm,
    output logic                             enable_psg,
    output logic [1:0]                       rotate
);

    wire [board_pkg::NUM_PLAYERS-1:0][board_pkg::BOARD_JOY_W-1:0] sync_joy;
    wire                                                        rot_control;

    player_if pl_if [board_pkg::NUM_PLAYERS] ();

    reset_seq u_reset (
        .clk_sys     ( clk_sys     ),
        .rst_n       ( rst_n       ),
        .pll_locked  ( pll_locked  ),
        .rst_req     ( rst_req     ),
        .downloading ( downloading ),
        .game_rst_n  ( game_rst_n  )
    );

    input_sampler u_sampler (
        .clk_sys   ( clk_sys   ),
        .rst_n     ( rst_n     ),
        .board_joy ( {board_joystick4, board_joystick3, board_joystick2, board_joystick1} ),
        .sync_joy  ( sync_joy  )
    );

    // One mapper per joystick port
    for (genvar g = 0; g < board_pkg::NUM_PLAYERS; g++) begin : g_player
        player_map u_map (
            .clk_sys     ( clk_sys     ),
            .rst_n       ( rst_n       ),
            .sync_joy    ( sync_joy[g] ),
            .rot_control ( rot_control ),
            .downloading ( downloading ),
            .out         ( pl_if[g]    )
        );
    end

    input_merge u_merge (
        .clk_sys      ( clk_sys      ),
        .rst_n        ( rst_n        ),
        .pl           ( pl_if        ),
        .pause_key    ( sync_joy[0][board_pkg::BIT_PAUSE] ),
        .game_joy     ( {game_joystick4, game_joystick3, game_joystick2, game_joystick1} ),
        .game_coin    ( game_coin    ),
        .game_start   ( game_start   ),
        .game_service ( game_service ),
        .game_pause   ( game_pause   )
    );

    dip_decode u_dip (
        .clk_sys     ( clk_sys     ),
        .rst_n       ( rst_n       ),
        .status      ( status      ),
        .core_mod    ( core_mod    ),
        .rot_control ( rot_control ),
        .rotate      ( rotate      ),
        .dip_flip    ( dip_flip    ),
        .dip_fxlevel ( dip_fxlevel ),
        .enable_fm   ( enable_fm   ),
        .enable_psg  ( enable_psg  ),
        .dip_test    ( dip_test    ),
        .dip_pause   ( dip_pause   )
    );

endmodule

//--- src/board_pkg.sv
package board_pkg;

    // Port counts and widths
    localparam int NUM_PLAYERS = 4;
    localparam int BOARD_JOY_W = 16;
    localparam int GAME_JOY_W  = 10;
    localparam int STATUS_W    = 32;
    localparam int CORE_MOD_W  = 7;

    // Buttons wired to the game, higher ones read as released
    localparam int NUM_BUTTONS = 2;

    // Game side inputs idle high when set
    localparam bit GAME_ACTIVE_LOW = 1'b1;
    localparam logic [GAME_JOY_W-1:0] GAME_JOY_IDLE = {GAME_JOY_W{GAME_ACTIVE_LOW}};

    // Game reset release delay in clk_sys cycles
    localparam int RESET_HOLD  = 16;
    localparam int RESET_CNT_W = $clog2(RESET_HOLD + 1);
    localparam logic [RESET_CNT_W-1:0] RESET_LOAD = RESET_HOLD[RESET_CNT_W-1:0];

    // Board joystick bits, game joystick uses the same order for 0 to 9
    localparam int BIT_RIGHT   = 0;
    localparam int BIT_LEFT    = 1;
    localparam int BIT_DOWN    = 2;
    localparam int BIT_UP      = 3;
    localparam int BIT_BTN0    = 4;
    localparam int BIT_COIN    = 10;
    localparam int BIT_START   = 11;
    localparam int BIT_SERVICE = 12;
    localparam int BIT_PAUSE   = 13;

    // OSD status word bits
    localparam int ST_ROTATE = 2;
    localparam int ST_FLIP   = 3;
    localparam int ST_FX     = 4;
    localparam int ST_NO_FM  = 6;
    localparam int ST_NO_PSG = 7;
    localparam int ST_TEST   = 8;
    localparam int ST_PAUSE  = 9;

    // core_mod bit 0 flags a vertical game
    localparam int CM_VERTICAL = 0;

endpackage

//--- src/dip_decode.sv
`timescale 1ns/1ps

module dip_decode (
    input  logic                             clk_sys,
    input  logic                             rst_n,
    input  logic [board_pkg::STATUS_W-1:0]   status,
    input  logic [board_pkg::CORE_MOD_W-1:0] core_mod,
    output logic                             rot_control,
    output logic [1:0]                       rotate,
    output logic                             dip_flip,
    output logic [1:0]                       dip_fxlevel,
    output logic                             enable_fm,
    output logic                             enable_psg,
    output logic                             dip_test,
    output logic                             dip_pause
);

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            rot_control <= 1'b0;
            dip_flip    <= 1'b0;
            dip_fxlevel <= 2'b00;
            enable_fm   <= 1'b0;
            enable_psg  <= 1'b0;
            dip_test    <= 1'b0;
            dip_pause   <= 1'b0;
        end else begin
            // Rotate controls only for a vertical game with the OSD option on
            rot_control <= core_mod[board_pkg::CM_VERTICAL] && status[board_pkg::ST_ROTATE];
            dip_flip    <= status[board_pkg::ST_FLIP];
            dip_fxlevel <= status[board_pkg::ST_FX +: 2];
            // OSD stores these as disable bits
            enable_fm   <= !status[board_pkg::ST_NO_FM];
            enable_psg  <= !status[board_pkg::ST_NO_PSG];
            dip_test    <= status[board_pkg::ST_TEST];
            dip_pause   <= status[board_pkg::ST_PAUSE];
        end
    end

    // Video rotation pair
    assign rotate = {rot_control, dip_flip};

endmodule

//--- src/input_merge.sv
`timescale 1ns/1ps

module input_merge (
    input  logic                           clk_sys,
    input  logic                           rst_n,
    player_if.merge                        pl [board_pkg::NUM_PLAYERS],
    input  logic                           pause_key,
    output logic [board_pkg::NUM_PLAYERS-1:0][board_pkg::GAME_JOY_W-1:0] game_joy,
    output logic [board_pkg::NUM_PLAYERS-1:0] game_coin,
    output logic [board_pkg::NUM_PLAYERS-1:0] game_start,
    output logic                           game_service,
    output logic                           game_pause
);

    localparam logic [board_pkg::NUM_PLAYERS-1:0] IDLE_BITS =
        {board_pkg::NUM_PLAYERS{board_pkg::GAME_ACTIVE_LOW}};

    logic [board_pkg::NUM_PLAYERS-1:0][board_pkg::GAME_JOY_W-1:0] joy_in;
    logic [board_pkg::NUM_PLAYERS-1:0] coin_in;
    logic [board_pkg::NUM_PLAYERS-1:0] start_in;
    logic [board_pkg::NUM_PLAYERS-1:0] service_in;
    logic                              service_any;
    logic                              pause_key_d;
    logic                              pause_rise;

    // Gather the players into vectors, bit i from player i
    for (genvar g = 0; g < board_pkg::NUM_PLAYERS; g++) begin : g_gather
        assign joy_in[g]     = pl[g].joy;
        assign coin_in[g]    = pl[g].coin;
        assign start_in[g]   = pl[g].start;
        assign service_in[g] = pl[g].service;
    end

    // Undo game polarity to find any pressed service key
    assign service_any = |(service_in ^ IDLE_BITS);
    assign pause_rise  = pause_key && !pause_key_d;

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            game_joy     <= {board_pkg::NUM_PLAYERS{board_pkg::GAME_JOY_IDLE}};
            game_coin    <= IDLE_BITS;
            game_start   <= IDLE_BITS;
            game_service <= board_pkg::GAME_ACTIVE_LOW;
            pause_key_d  <= 1'b0;
            game_pause   <= 1'b0;
        end else begin
            game_joy     <= joy_in;
            game_coin    <= coin_in;
            game_start   <= start_in;
            game_service <= service_any ^ board_pkg::GAME_ACTIVE_LOW;
            pause_key_d  <= pause_key;
            // One toggle per press
            if (pause_rise) begin
                game_pause <= !game_pause;
            end
        end
    end

    pause_needs_press: assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        !$stable(game_pause) |-> $past(pause_rise)
    );

endmodule

//--- src/input_sampler.sv
`timescale 1ns/1ps

module input_sampler (
    input  logic clk_sys,
    input  logic rst_n,
    input  logic [board_pkg::NUM_PLAYERS-1:0][board_pkg::BOARD_JOY_W-1:0] board_joy,
    output logic [board_pkg::NUM_PLAYERS-1:0][board_pkg::BOARD_JOY_W-1:0] sync_joy
);

    // First stage may go metastable
    logic [board_pkg::NUM_PLAYERS-1:0][board_pkg::BOARD_JOY_W-1:0] meta_joy;

    // Two flops per bit, board inputs are asynchronous to clk_sys
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            // Zero is the released level on the board side
            meta_joy <= '0;
            sync_joy <= '0;
        end else begin
            meta_joy <= board_joy;
            sync_joy <= meta_joy;
        end
    end

endmodule

//--- src/player_if.sv
`timescale 1ns/1ps

// One mapped player, already at game polarity
interface player_if;

    logic [board_pkg::GAME_JOY_W-1:0] joy;
    logic                             coin;
    logic                             start;
    logic                             service;

    // Mapper side
    modport map (
        output joy,
        output coin,
        output start,
        output service
    );

    // Merge side
    modport merge (
        input joy,
        input coin,
        input start,
        input service
    );

endinterface

//--- src/player_map.sv
`timescale 1ns/1ps

module player_map (
    input  logic                              clk_sys,
    input  logic                              rst_n,
    input  logic [board_pkg::BOARD_JOY_W-1:0] sync_joy,
    input  logic                              rot_control,
    input  logic                              downloading,
    player_if.map                             out
);

    localparam int NUM_BTN_BITS = board_pkg::GAME_JOY_W - board_pkg::BIT_BTN0;

    logic [board_pkg::GAME_JOY_W-1:0] joy_act;
    logic [board_pkg::GAME_JOY_W-1:0] joy_game;

    // Mapping at active high level before polarity
    always_comb begin
        joy_act = sync_joy[board_pkg::GAME_JOY_W-1:0];
        // Directions turn 90 degrees for a vertical game on a horizontal screen
        if (rot_control) begin
            joy_act[board_pkg::BIT_UP]    = sync_joy[board_pkg::BIT_RIGHT];
            joy_act[board_pkg::BIT_LEFT]  = sync_joy[board_pkg::BIT_UP];
            joy_act[board_pkg::BIT_DOWN]  = sync_joy[board_pkg::BIT_LEFT];
            joy_act[board_pkg::BIT_RIGHT] = sync_joy[board_pkg::BIT_DOWN];
        end
        for (int i = 0; i < NUM_BTN_BITS; i++) begin
            if (i >= board_pkg::NUM_BUTTONS) begin
                joy_act[board_pkg::BIT_BTN0 + i] = 1'b0;
            end
        end
    end

    assign joy_game = joy_act ^ board_pkg::GAME_JOY_IDLE;

    // Inputs locked at idle while a ROM download runs
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            out.joy     <= board_pkg::GAME_JOY_IDLE;
            out.coin    <= board_pkg::GAME_ACTIVE_LOW;
            out.start   <= board_pkg::GAME_ACTIVE_LOW;
            out.service <= board_pkg::GAME_ACTIVE_LOW;
        end else if (downloading) begin
            out.joy     <= board_pkg::GAME_JOY_IDLE;
            out.coin    <= board_pkg::GAME_ACTIVE_LOW;
            out.start   <= board_pkg::GAME_ACTIVE_LOW;
            out.service <= board_pkg::GAME_ACTIVE_LOW;
        end else begin
            out.joy     <= joy_game;
            out.coin    <= sync_joy[board_pkg::BIT_COIN] ^ board_pkg::GAME_ACTIVE_LOW;
            out.start   <= sync_joy[board_pkg::BIT_START] ^ board_pkg::GAME_ACTIVE_LOW;
            out.service <= sync_joy[board_pkg::BIT_SERVICE] ^ board_pkg::GAME_ACTIVE_LOW;
        end
    end

    // Nothing from the board leaks through during a download
    idle_while_locked: assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        downloading |=> (out.joy == board_pkg::GAME_JOY_IDLE)
                        && (out.coin == board_pkg::GAME_ACTIVE_LOW)
                        && (out.start == board_pkg::GAME_ACTIVE_LOW)
                        && (out.service == board_pkg::GAME_ACTIVE_LOW)
    );

endmodule

//--- src/reset_seq.sv
`timescale 1ns/1ps

module reset_seq (
    input  logic clk_sys,
    input  logic rst_n,
    input  logic pll_locked,
    input  logic rst_req,
    input  logic downloading,
    output logic game_rst_n
);

    logic                                hold_cause;
    logic [board_pkg::RESET_CNT_W-1:0]   hold_cnt;

    // Any of these keeps the game in reset
    assign hold_cause = !pll_locked || rst_req || downloading;

    // Counter reloads while a cause is present, release once it has run out
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            hold_cnt   <= board_pkg::RESET_LOAD;
            game_rst_n <= 1'b0;
        end else if (hold_cause) begin
            hold_cnt   <= board_pkg::RESET_LOAD;
            game_rst_n <= 1'b0;
        end else if (hold_cnt != '0) begin
            hold_cnt   <= hold_cnt - 1'b1;
        end else begin
            game_rst_n <= 1'b1;
        end
    end

    // Losing lock must always pull the game into reset on the next edge
    pll_holds_reset: assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        !pll_locked |=> !game_rst_n
    );

    // Release only after a full hold period free of causes
    release_after_hold: assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        $rose(game_rst_n) |-> $past(!hold_cause, board_pkg::RESET_HOLD + 1)
    );

endmodule

//--- testbench/tb_board_io.sv
`timescale 1ns/1ps

module tb_board_io;

    localparam int NUM_RAND    = 200;
    localparam int NUM_LOCK    = 20;
    localparam int NUM_PAUSE   = 4;
    localparam int NUM_VECTORS = NUM_RAND + NUM_LOCK + 2 * NUM_PAUSE;
    localparam int WATCHDOG    = NUM_VECTORS * 10 + 200;

    logic clk_sys = 1'b0;
    logic rst_n;
    logic pll_locked;
    logic rst_req;
    logic downloading;
    logic [board_pkg::NUM_PLAYERS-1:0][board_pkg::BOARD_JOY_W-1:0] board_joy;
    logic [board_pkg::STATUS_W-1:0]   status;
    logic [board_pkg::CORE_MOD_W-1:0] core_mod;
    logic                             game_rst_n;
    logic [board_pkg::NUM_PLAYERS-1:0][board_pkg::GAME_JOY_W-1:0] game_joy;
    logic [board_pkg::NUM_PLAYERS-1:0] game_coin;
    logic [board_pkg::NUM_PLAYERS-1:0] game_start;
    logic game_service;
    logic game_pause;
    logic dip_test;
    logic dip_pause;
    logic dip_flip;
    logic [1:0] dip_fxlevel;
    logic enable_fm;
    logic enable_psg;
    logic [1:0] rotate;
    logic [31:0] lcg_state = 32'd54995;
    int          checks = 0;
    int          errors = 0;

    always #4 clk_sys = ~clk_sys;

    board_io_top dut (
        .clk_sys         ( clk_sys      ),
        .rst_n           ( rst_n        ),
        .pll_locked      ( pll_locked   ),
        .rst_req         ( rst_req      ),
        .downloading     ( downloading  ),
        .board_joystick1 ( board_joy[0] ),
        .board_joystick2 ( board_joy[1] ),
        .board_joystick3 ( board_joy[2] ),
        .board_joystick4 ( board_joy[3] ),
        .status          ( status       ),
        .core_mod        ( core_mod     ),
        .game_rst_n      ( game_rst_n   ),
        .game_joystick1  ( game_joy[0]  ),
        .game_joystick2  ( game_joy[1]  ),
        .game_joystick3  ( game_joy[2]  ),
        .game_joystick4  ( game_joy[3]  ),
        .game_coin       ( game_coin    ),
        .game_start      ( game_start   ),
        .game_service    ( game_service ),
        .game_pause      ( game_pause   ),
        .dip_test        ( dip_test     ),
        .dip_pause       ( dip_pause    ),
        .dip_flip        ( dip_flip     ),
        .dip_fxlevel     ( dip_fxlevel  ),
        .enable_fm       ( enable_fm    ),
        .enable_psg      ( enable_psg   ),
        .rotate          ( rotate       )
    );

    // LCG step returning the upper half of the state
    function automatic logic [15:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    // Reference mapping of one board word to the game joystick
    function automatic logic [board_pkg::GAME_JOY_W-1:0] expected_joy(
        input logic [board_pkg::BOARD_JOY_W-1:0] b,
        input logic                              rot
    );
        logic [board_pkg::GAME_JOY_W-1:0] j;
        j = b[board_pkg::GAME_JOY_W-1:0];
        if (rot) begin
            j[board_pkg::BIT_UP]    = b[board_pkg::BIT_RIGHT];
            j[board_pkg::BIT_LEFT]  = b[board_pkg::BIT_UP];
            j[board_pkg::BIT_DOWN]  = b[board_pkg::BIT_LEFT];
            j[board_pkg::BIT_RIGHT] = b[board_pkg::BIT_DOWN];
        end
        for (int k = board_pkg::BIT_BTN0 + board_pkg::NUM_BUTTONS;
             k < board_pkg::GAME_JOY_W; k++) begin
            j[k] = 1'b0;
        end
        return board_pkg::GAME_ACTIVE_LOW ? ~j : j;
    endfunction

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("Error at %0t ns: %s expected %h, got %h", $time, what, expected, actual);
        end
    endtask

    // Step to the drive point just after a rising edge
    task automatic advance(input int n);
        repeat (n) @(posedge clk_sys);
        #1;
    endtask

    initial begin : main_flow
        logic [15:0] r;
        logic        rot;
        logic        exp_pause;
        logic        svc_any;
        logic [board_pkg::NUM_PLAYERS-1:0] exp_coin;
        logic [board_pkg::NUM_PLAYERS-1:0] exp_start;
        logic [board_pkg::GAME_JOY_W-1:0]  idle_joy;
        idle_joy    = {board_pkg::GAME_JOY_W{board_pkg::GAME_ACTIVE_LOW}};
        exp_pause   = 1'b0;
        rst_n       = 1'b0;
        pll_locked  = 1'b0;
        rst_req     = 1'b0;
        downloading = 1'b0;
        board_joy   = '0;
        status      = '0;
        core_mod    = '0;
        advance(16);
        rst_n = 1'b1;

        // Game reset held by the PLL and then by the request
        check_value("game_rst_n after reset", 0, game_rst_n);
        advance(4);
        check_value("game_rst_n pll unlocked", 0, game_rst_n);
        pll_locked = 1'b1;
        rst_req    = 1'b1;
        advance(4);
        check_value("game_rst_n reset request", 0, game_rst_n);
        rst_req = 1'b0;
        for (int i = 1; i <= board_pkg::RESET_HOLD + 1; i++) begin
            advance(1);
            check_value("game_rst_n release", (i > board_pkg::RESET_HOLD), game_rst_n);
        end

        // Download drops the game reset and locks every input at idle
        downloading = 1'b1;
        for (int i = 1; i <= NUM_LOCK; i++) begin
            advance(1);
            if (i == 1) begin
                check_value("game_rst_n on download", 0, game_rst_n);
            end
            if (i >= 2) begin
                check_value("locked joysticks", {board_pkg::NUM_PLAYERS{idle_joy}}, game_joy);
                check_value("locked coin/start/service",
                            {(2 * board_pkg::NUM_PLAYERS + 1){board_pkg::GAME_ACTIVE_LOW}},
                            {game_service, game_start, game_coin});
            end
            // Pause is not locked, keep it released here
            for (int p = 0; p < board_pkg::NUM_PLAYERS; p++) begin
                r = next_random();
                r[board_pkg::BIT_PAUSE] = 1'b0;
                board_joy[p] = r;
            end
        end
        downloading = 1'b0;

        for (int v = 0; v < NUM_RAND; v++) begin
            // Pause bit kept low for the separate press tests
            for (int p = 0; p < board_pkg::NUM_PLAYERS; p++) begin
                r = next_random();
                r[board_pkg::BIT_PAUSE] = 1'b0;
                board_joy[p] = r;
            end
            status   = {next_random(), next_random()};
            r        = next_random();
            core_mod = r[board_pkg::CORE_MOD_W-1:0];
            rot      = core_mod[board_pkg::CM_VERTICAL] && status[board_pkg::ST_ROTATE];
            advance(2);
            check_value("dip outputs",
                        {rot, status[board_pkg::ST_FLIP], status[board_pkg::ST_TEST],
                         status[board_pkg::ST_PAUSE], status[board_pkg::ST_FLIP],
                         status[board_pkg::ST_FX +: 2], !status[board_pkg::ST_NO_FM],
                         !status[board_pkg::ST_NO_PSG]},
                        {rotate, dip_test, dip_pause, dip_flip, dip_fxlevel, enable_fm,
                         enable_psg});
            advance(4);
            svc_any = 1'b0;
            for (int p = 0; p < board_pkg::NUM_PLAYERS; p++) begin
                check_value($sformatf("player %0d joystick", p + 1),
                            expected_joy(board_joy[p], rot), game_joy[p]);
                exp_coin[p]  = board_joy[p][board_pkg::BIT_COIN] ^ board_pkg::GAME_ACTIVE_LOW;
                exp_start[p] = board_joy[p][board_pkg::BIT_START] ^ board_pkg::GAME_ACTIVE_LOW;
                svc_any      = svc_any | board_joy[p][board_pkg::BIT_SERVICE];
            end
            check_value("coin/start/service",
                        {svc_any ^ board_pkg::GAME_ACTIVE_LOW, exp_start, exp_coin},
                        {game_service, game_start, game_coin});
            advance(2);
        end

        // Each press and release of pause flips game_pause once
        board_joy = '0;
        for (int n = 0; n < NUM_PAUSE; n++) begin
            board_joy[0][board_pkg::BIT_PAUSE] = 1'b1;
            advance(6);
            exp_pause = !exp_pause;
            check_value("game_pause after press", exp_pause, game_pause);
            board_joy[0][board_pkg::BIT_PAUSE] = 1'b0;
            advance(6);
            check_value("game_pause after release", exp_pause, game_pause);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG) @(posedge clk_sys);
        $display("Timeout: run did not finish within %0d clock cycles", WATCHDOG);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Testbench failed");
        $finish;
    end

endmodule
